//--- flist.f
source/tmu_pix_pkg.sv
source/tmu_regs_pkg.sv
source/tmu_ctlif.sv
source/tmu_clip_adr.sv
source/tmu_decay.sv
source/tmu_burst.sv
source/tmu_pixout.sv
source/tmu_top.sv
test/tmu_assertions.sv
test/tmu_tb.sv

//--- Bender.yml
package:
  name: tmu_pix_backend

sources:
  - files:
      - source/tmu_pix_pkg.sv
      - source/tmu_regs_pkg.sv
      - source/tmu_ctlif.sv
      - source/tmu_clip_adr.sv
      - source/tmu_decay.sv
      - source/tmu_burst.sv
      - source/tmu_pixout.sv
      - source/tmu_top.sv
  - target: test
    files:
      - test/tmu_assertions.sv
      - test/tmu_tb.sv

//--- test/tmu_tb.sv
// ====================
// testbench for the TMU pixel back end with
// stimulus, memory model, reference and checks.
// ====================

`timescale 1ns/100ps

module tmu_tb
	import tmu_pix_pkg::*;
	import tmu_regs_pkg::*;
();

	localparam int half_period = 20;
	localparam int total_pixels = 64 + 200 + 100 + 64;
	localparam int cycle_limit = 20 * total_pixels + 2000;

	typedef struct packed {
		logic keep;
		logic [dadr_w-1:0] adr;
		rgb565_t color;
	} ref_pix_t;

	logic sys_clk;
	logic sys_rst;
	logic [13:0] csr_a_i;
	logic csr_we_i;
	logic [31:0] csr_di_i;
	logic [31:0] csr_do_o;
	logic pix_stb_i;
	logic pix_ack_o;
	pix_in_t pix_i;
	logic [fml_depth-1:0] fmlw_adr_o;
	logic fmlw_stb_o;
	logic fmlw_ack_i;
	logic [7:0] fmlw_sel_o;
	logic [63:0] fmlw_do_o;
	logic irq_o;

	logic [31:0] rng_state = 32'h4e267a14;

	// copy of the configuration held by the DUT.
	logic [5:0] cfg_bright;
	logic cfg_key_en;
	rgb565_t cfg_key;
	logic [dadr_w-1:0] cfg_fbuf;
	res_t cfg_hres;
	res_t cfg_vres;

	// word-addressed framebuffer, written and expected.
	logic [15:0] mem [int];
	logic [15:0] exp_mem [int];
	pix_in_t stim [$];

	int checks = 0;
	int errors = 0;
	int tests_run = 0;
	int burst_count = 0;
	int irq_count = 0;
	int cycles = 0;
	logic compare_req = 1'b0;

	tmu_top tmu_top_i (.*);

	initial begin
		sys_clk = 1'b0;
		forever #half_period sys_clk = ~sys_clk;
	end

	function automatic logic [31:0] next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic rgb565_t rand_color();
		logic [31:0] r;
		r = next_rand();
		return r[15:0];
	endfunction

	// expected outcome of one pixel.
	function automatic ref_pix_t ref_pixel(input pix_in_t p);
		ref_pix_t r;
		int xi;
		int yi;
		int gain;
		logic on_screen;
		xi = $signed(p.x);
		yi = $signed(p.y);
		gain = cfg_bright + 1;
		on_screen = xi >= 0 && yi >= 0 && xi < int'(cfg_hres) && yi < int'(cfg_vres);
		r.keep = on_screen && !(cfg_key_en && p.color == cfg_key);
		r.adr = dadr_w'(int'(cfg_fbuf) + yi * int'(cfg_hres) + xi);
		r.color.r = 5'(int'(p.color.r) * gain / 64);
		r.color.g = 6'(int'(p.color.g) * gain / 64);
		r.color.b = 5'(int'(p.color.b) * gain / 64);
		return r;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("ERROR at %0t: %s = %h, expected %h", $time, name, got, expected);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before)
			$display("test %0d, %s: ok", tests_run, name);
		else
			$display("test %0d, %s: %0d errors", tests_run, name, errors - errs_before);
	endtask

	task automatic csr_write(input logic [9:0] word, input logic [31:0] data);
		@(negedge sys_clk);
		csr_a_i = {csr_sel, word};
		csr_we_i = 1'b1;
		csr_di_i = data;
		@(negedge sys_clk);
		csr_we_i = 1'b0;
	endtask

	// read data is registered, so it is taken one cycle later.
	task automatic csr_read(input logic [9:0] word, output logic [31:0] data);
		@(negedge sys_clk);
		csr_a_i = {csr_sel, word};
		csr_we_i = 1'b0;
		@(negedge sys_clk);
		data = csr_do_o;
	endtask

	task automatic write_readback(input logic [9:0] word, input logic [31:0] data,
		input string name);
		logic [31:0] rd;
		csr_write(word, data);
		csr_read(word, rd);
		check_value(name, rd, data);
	endtask

	task automatic configure(input logic [5:0] bright, input logic key_en,
		input rgb565_t key, input logic [dadr_w-1:0] fbuf, input res_t hres,
		input res_t vres);
		cfg_bright = bright;
		cfg_key_en = key_en;
		cfg_key = key;
		cfg_fbuf = fbuf;
		cfg_hres = hres;
		cfg_vres = vres;
		csr_write(reg_brightness, 32'(bright));
		csr_write(reg_chroma_key, 32'(key));
		csr_write(reg_dst_fbuf, 32'(fbuf));
		csr_write(reg_dst_hres, 32'(hres));
		csr_write(reg_dst_vres, 32'(vres));
	endtask

	task automatic add_pixel(input int x, input int y, input rgb565_t color);
		pix_in_t p;
		p.x = coord_t'(x);
		p.y = coord_t'(y);
		p.color = color;
		p.last = 1'b0;
		stim.push_back(p);
	endtask

	// hold the strobe until a cycle with the ack high.
	task automatic send_pixel(input pix_in_t p);
		logic acked;
		@(negedge sys_clk);
		pix_stb_i = 1'b1;
		pix_i = p;
		acked = 1'b0;
		while (!acked) begin
			#(half_period / 2);
			acked = pix_ack_o;
			@(posedge sys_clk);
			if (!acked)
				@(negedge sys_clk);
		end
	endtask

	task automatic store_beat(input logic [dadr_w-1:0] adr);
		logic hi;
		logic lo;
		for (int s = 0; s < 4; s++) begin
			hi = fmlw_sel_o[7 - 2*s];
			lo = fmlw_sel_o[6 - 2*s];
			if (hi != lo) begin
				errors++;
				$display("ERROR at %0t: the two select bits of slot %0d differ", $time, s);
			end else if (hi)
				mem[adr + s] = fmlw_do_o[63 - 16*s -: 16];
		end
	endtask

	// one run over the queued pixels, then all end-of-run checks.
	task automatic do_run();
		ref_pix_t rp;
		pix_in_t p;
		int bursts_exp;
		int bursts_before;
		int irqs_before;
		logic have_adr;
		logic [burst_adr_w-1:0] last_badr;
		logic [31:0] rd;
		bursts_exp = 0;
		have_adr = 1'b0;
		last_badr = '0;
		bursts_before = burst_count;
		irqs_before = irq_count;
		csr_write(reg_ctrl, {30'd0, cfg_key_en, 1'b1});
		foreach (stim[i]) begin
			p = stim[i];
			p.last = (i == stim.size() - 1);
			send_pixel(p);
			rp = ref_pixel(p);
			if (rp.keep) begin
				exp_mem[rp.adr] = rp.color;
				// a new burst each time the burst address changes.
				if (!have_adr || rp.adr[dadr_w-1:4] != last_badr)
					bursts_exp++;
				have_adr = 1'b1;
				last_badr = rp.adr[dadr_w-1:4];
			end
		end
		@(negedge sys_clk);
		pix_stb_i = 1'b0;
		while (!irq_o)
			@(negedge sys_clk);
		repeat (4) @(negedge sys_clk);
		check_value("irq_o pulses", irq_count - irqs_before, 1);
		check_value("bursts written", burst_count - bursts_before, bursts_exp);
		csr_read(reg_ctrl, rd);
		check_value("ctrl busy", rd[ctrl_busy_bit], 0);
		compare_req = 1'b1;
		wait (!compare_req);
	endtask

	always @(negedge sys_clk)
		if (irq_o)
			irq_count++;

	initial begin : memory_model
		int delay;
		logic [dadr_w-1:0] base;
		fmlw_ack_i = 1'b0;
		forever begin
			@(negedge sys_clk);
			if (fmlw_stb_o) begin
				delay = next_rand() % 4;
				repeat (delay) @(negedge sys_clk);
				fmlw_ack_i = 1'b1;
				base = fmlw_adr_o[fml_depth-1:1];
				check_value("fmlw_adr_o[4:0]", fmlw_adr_o[4:0], 0);
				// beat 0 on the ack cycle, then one beat per cycle.
				for (int b = 0; b < beats_per_burst; b++) begin
					if (b > 0) begin
						@(negedge sys_clk);
						fmlw_ack_i = 1'b0;
					end
					#(half_period / 2);
					store_beat(base + 4*b);
				end
				burst_count++;
			end
		end
	end

	initial begin : compare_image
		forever begin
			wait (compare_req);
			foreach (exp_mem[a]) begin
				if (!mem.exists(a)) begin
					errors++;
					$display("ERROR at %0t: word %h was never written", $time, a);
				end else
					check_value($sformatf("mem[%h]", a), mem[a], exp_mem[a]);
			end
			foreach (mem[a]) begin
				if (!exp_mem.exists(a)) begin
					errors++;
					$display("ERROR at %0t: word %h was written but should be untouched",
						$time, a);
				end
			end
			compare_req = 1'b0;
		end
	end

	initial begin : watchdog
		while (cycles < cycle_limit) begin
			@(posedge sys_clk);
			cycles++;
		end
		$display("timeout: the run did not end within %0d clock cycles", cycle_limit);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin : main
		logic [31:0] rd;
		int n;
		int errs;
		sys_rst = 1'b1;
		csr_a_i = '0;
		csr_we_i = 1'b0;
		csr_di_i = '0;
		pix_stb_i = 1'b0;
		pix_i = '0;
		repeat (8) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0;

		errs = errors;
		check_value("irq_o", irq_o, 0);
		check_value("fmlw_stb_o", fmlw_stb_o, 0);
		check_value("pix_ack_o", pix_ack_o, 0);
		csr_read(reg_ctrl, rd);
		check_value("ctrl busy", rd[ctrl_busy_bit], 0);
		write_readback(reg_brightness, 32'h2a, "brightness");
		write_readback(reg_chroma_key, 32'hb5e3, "chroma_key");
		write_readback(reg_dst_fbuf, 32'h0abcdef, "dst_fbuf");
		write_readback(reg_dst_hres, 32'h2ab, "dst_hres");
		write_readback(reg_dst_vres, 32'h155, "dst_vres");
		write_readback(reg_ctrl, 32'h2, "ctrl key enable");
		csr_write(reg_ctrl, 32'h0);
		report_test("reset and registers", errs);

		errs = errors;
		configure(6'd63, 1'b0, '0, 25'h1000, 11'd32, 11'd16);
		stim.delete();
		for (int i = 0; i < 64; i++)
			add_pixel(i % 32, i / 32, rand_color());
		do_run();
		// full brightness keeps each colour as sent.
		for (int i = 0; i < 64; i++)
			check_value("sequential pixel", mem[cfg_fbuf + i], stim[i].color);
		report_test("sequential full brightness", errs);

		errs = errors;
		configure(6'(next_rand()), 1'b0, '0, 25'h20000, 11'd40, 11'd30);
		stim.delete();
		for (int i = 0; i < 200; i++)
			add_pixel(int'(next_rand() % 56) - 8, int'(next_rand() % 46) - 8, rand_color());
		do_run();
		report_test("random clip and decay", errs);

		errs = errors;
		configure(6'(next_rand()), 1'b1, 16'h7c1f, 25'h40000, 11'd64, 11'd32);
		stim.delete();
		for (int i = 0; i < 100; i++)
			add_pixel(int'(next_rand() % 64), int'(next_rand() % 32),
				(next_rand() % 2) ? cfg_key : rand_color());
		do_run();
		report_test("chroma key", errs);

		errs = errors;
		configure(6'(next_rand()), 1'b0, '0, 25'h60000, 11'd64, 11'd8);
		n = 16 * (1 + int'(next_rand() % 3)) + 1 + int'(next_rand() % 15);
		stim.delete();
		for (int i = 0; i < n; i++)
			add_pixel(i % 64, i / 64, rand_color());
		do_run();
		report_test($sformatf("partial burst flush, %0d pixels", n), errs);

		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- test/tmu_assertions.sv
// ====================
// bound assertions on the memory
// write port and the irq pulse.
// ====================

`timescale 1ns/100ps

module tmu_assertions (
	input logic       sys_clk,
	input logic       sys_rst,
	input logic       fmlw_stb_o,
	input logic       fmlw_ack_i,
	input logic [7:0] fmlw_sel_o,
	input logic       irq_o
);

	logic grant;
	logic [1:0] beat;
	logic sel_seen;

	assign grant = fmlw_stb_o & fmlw_ack_i;

	// index of the beat after the ack cycle, zero when the port is quiet.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			beat <= '0;
			sel_seen <= 1'b0;
		end else if (grant) begin
			beat <= 2'd1;
			sel_seen <= |fmlw_sel_o;
		end else if (beat != 2'd0) begin
			beat <= beat + 2'd1;
			sel_seen <= sel_seen | (|fmlw_sel_o);
		end
	end

	stb_held: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fmlw_stb_o && !fmlw_ack_i |=> fmlw_stb_o)
		else $error("fmlw_stb_o dropped before fmlw_ack_i");

	sel_quiet: assert property (@(posedge sys_clk) disable iff (sys_rst)
		beat == 2'd0 && !grant |-> fmlw_sel_o == 8'd0)
		else $error("fmlw_sel_o active outside a burst");

	// a burst selects at least one pixel on one of its beats.
	sel_used: assert property (@(posedge sys_clk) disable iff (sys_rst)
		beat == 2'd3 |-> sel_seen || fmlw_sel_o != 8'd0)
		else $error("burst written with no select bit set");

	irq_pulse: assert property (@(posedge sys_clk) disable iff (sys_rst)
		irq_o |=> !irq_o)
		else $error("irq_o high for more than one cycle");

	reset_quiet: assert property (@(posedge sys_clk)
		sys_rst |=> !irq_o && !fmlw_stb_o)
		else $error("irq_o or fmlw_stb_o high after reset");

endmodule

bind tmu_top tmu_assertions tmu_assertions_i (.*);

//--- source/tmu_top.sv
// ====================
// TMU pixel back end top level.
// ====================

`timescale 1ns/100ps

module tmu_top
	import tmu_pix_pkg::*;
	import tmu_regs_pkg::*;
(
	input  logic                 sys_clk,
	input  logic                 sys_rst,
	input  logic [13:0]          csr_a_i,
	input  logic                 csr_we_i,
	input  logic [31:0]          csr_di_i,
	output logic [31:0]          csr_do_o,
	input  logic                 pix_stb_i,
	output logic                 pix_ack_o,
	input  pix_in_t              pix_i,
	output logic [fml_depth-1:0] fmlw_adr_o,
	output logic                 fmlw_stb_o,
	input  logic                 fmlw_ack_i,
	output logic [7:0]           fmlw_sel_o,
	output logic [63:0]          fmlw_do_o,
	output logic                 irq_o
);

	wire tmu_busy_t stage_busy;
	tmu_cfg_t cfg;
	logic run;
	logic flush;
	logic last_done;
	logic adr_stb;
	logic adr_ack;
	logic adr_valid;
	pix_adr_t adr_pix;
	logic dec_stb;
	logic dec_ack;
	logic dec_valid;
	pix_adr_t dec_pix;
	logic bst_stb;
	logic bst_ack;
	burst_t bst;

	tmu_ctlif ctlif_i (
		.sys_clk, .sys_rst, .csr_a_i, .csr_we_i, .csr_di_i, .csr_do_o,
		.stage_busy_i(stage_busy), .last_done_i(last_done), .cfg_o(cfg),
		.run_o(run), .flush_o(flush), .irq_o
	);

	tmu_clip_adr clip_adr_i (
		.sys_clk, .sys_rst, .run_i(run),
		.pipe_stb_i(pix_stb_i), .pipe_ack_o(pix_ack_o), .pix_i,
		.dst_fbuf_i(cfg.dst_fbuf), .dst_hres_i(cfg.dst_hres), .dst_vres_i(cfg.dst_vres),
		.pipe_stb_o(adr_stb), .pipe_ack_i(adr_ack), .pix_o(adr_pix), .valid_o(adr_valid),
		.busy_o(stage_busy.clip_adr)
	);

	tmu_decay decay_i (
		.sys_clk, .sys_rst, .brightness_i(cfg.brightness),
		.chroma_key_en_i(cfg.chroma_key_en), .chroma_key_i(cfg.chroma_key),
		.pipe_stb_i(adr_stb), .pipe_ack_o(adr_ack), .valid_i(adr_valid), .pix_i(adr_pix),
		.pipe_stb_o(dec_stb), .pipe_ack_i(dec_ack), .valid_o(dec_valid), .pix_o(dec_pix),
		.last_done_o(last_done), .busy_o(stage_busy.decay)
	);

	tmu_burst burst_i (
		.sys_clk, .sys_rst, .flush_i(flush),
		.pipe_stb_i(dec_stb), .pipe_ack_o(dec_ack), .valid_i(dec_valid), .pix_i(dec_pix),
		.pipe_stb_o(bst_stb), .pipe_ack_i(bst_ack), .burst_o(bst),
		.busy_o(stage_busy.burst)
	);

	tmu_pixout pixout_i (
		.sys_clk, .sys_rst,
		.pipe_stb_i(bst_stb), .pipe_ack_o(bst_ack), .burst_i(bst),
		.fmlw_adr_o, .fmlw_stb_o, .fmlw_ack_i, .fmlw_sel_o, .fmlw_do_o,
		.busy_o(stage_busy.pixout)
	);

endmodule

//--- source/tmu_pixout.sv
// ====================
// four-beat burst writer.
// ====================

`timescale 1ns/100ps

module tmu_pixout
	import tmu_pix_pkg::*;
(
	input  logic                 sys_clk,
	input  logic                 sys_rst,
	input  logic                 pipe_stb_i,
	output logic                 pipe_ack_o,
	input  burst_t               burst_i,
	output logic [fml_depth-1:0] fmlw_adr_o,
	output logic                 fmlw_stb_o,
	input  logic                 fmlw_ack_i,
	output logic [7:0]           fmlw_sel_o,
	output logic [63:0]          fmlw_do_o,
	output logic                 busy_o
);

	localparam int beat_w = $clog2(beats_per_burst);

	burst_t held;
	logic bursting;
	logic [beat_w-1:0] beat;
	logic grant;
	logic [3:0] beat_sel;

	assign busy_o = fmlw_stb_o | bursting;
	assign pipe_ack_o = ~busy_o;
	assign grant = fmlw_stb_o & fmlw_ack_i;
	assign fmlw_adr_o = {held.burst_addr, 5'd0};
	// beat 0 goes out on the ack cycle itself.
	assign fmlw_do_o = held.data[{~beat, 6'd0} +: 64];
	assign beat_sel = held.sel[{~beat, 2'd0} +: 4];

	always_comb begin
		fmlw_sel_o = '0;
		for (int i = 0; i < 4; i++)
			fmlw_sel_o[2*i +: 2] = {2{beat_sel[i] & (grant | bursting)}};
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			fmlw_stb_o <= 1'b0;
			bursting <= 1'b0;
			beat <= '0;
		end else if (grant) begin
			fmlw_stb_o <= 1'b0;
			bursting <= 1'b1;
			beat <= beat_w'(1);
		end else if (bursting) begin
			beat <= beat + 1'b1;
			if (beat == beat_w'(beats_per_burst - 1))
				bursting <= 1'b0;
		end else if (pipe_stb_i) begin
			fmlw_stb_o <= 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (pipe_stb_i && pipe_ack_o)
			held <= burst_i;
	end

endmodule

//--- source/tmu_burst.sv
// ====================
// burst assembler with select mask.
// ====================

`timescale 1ns/100ps

module tmu_burst
	import tmu_pix_pkg::*;
(
	input  logic     sys_clk,
	input  logic     sys_rst,
	input  logic     flush_i,
	input  logic     pipe_stb_i,
	output logic     pipe_ack_o,
	input  logic     valid_i,
	input  pix_adr_t pix_i,
	output logic     pipe_stb_o,
	input  logic     pipe_ack_i,
	output burst_t   burst_o,
	output logic     busy_o
);

	logic [burst_adr_w-1:0] cur_addr;
	logic [pixels_per_burst-1:0] cur_sel;
	logic [pixels_per_burst*16-1:0] cur_data;
	logic [burst_adr_w-1:0] new_addr;
	logic [3:0] pos;
	logic [pixels_per_burst-1:0] slot_mask;
	logic xfer;
	logic take;
	logic split;
	logic flush_emit;

	assign pipe_ack_o = ~pipe_stb_o | pipe_ack_i;
	assign xfer = pipe_stb_i & pipe_ack_o;
	assign busy_o = pipe_stb_o;
	assign new_addr = pix_i.dadr[dadr_w-1:4];
	// slot 0 sits in the top bits.
	assign pos = ~pix_i.dadr[3:0];

	always_comb begin
		slot_mask = '0;
		slot_mask[pos] = 1'b1;
		take = xfer & valid_i;
		split = take & (|cur_sel) & (new_addr != cur_addr);
		flush_emit = flush_i & ~xfer & (|cur_sel) & pipe_ack_o;
	end

	// markers without a valid pixel are consumed here.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pipe_stb_o <= 1'b0;
			cur_sel <= '0;
		end else begin
			if (split || flush_emit)
				pipe_stb_o <= 1'b1;
			else if (pipe_ack_i)
				pipe_stb_o <= 1'b0;
			if (take)
				cur_sel <= (split ? '0 : cur_sel) | slot_mask;
			else if (flush_emit)
				cur_sel <= '0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (split || flush_emit) begin
			burst_o.burst_addr <= cur_addr;
			burst_o.sel <= cur_sel;
			burst_o.data <= cur_data;
		end
		if (take) begin
			cur_addr <= new_addr;
			cur_data[{pos, 4'd0} +: 16] <= pix_i.color;
		end
	end

endmodule

//--- source/tmu_decay.sv
// ====================
// brightness scaling and chroma key.
// ====================

`timescale 1ns/100ps

module tmu_decay
	import tmu_pix_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst,
	input  logic [5:0] brightness_i,
	input  logic       chroma_key_en_i,
	input  rgb565_t    chroma_key_i,
	input  logic       pipe_stb_i,
	output logic       pipe_ack_o,
	input  logic       valid_i,
	input  pix_adr_t   pix_i,
	output logic       pipe_stb_o,
	input  logic       pipe_ack_i,
	output logic       valid_o,
	output pix_adr_t   pix_o,
	output logic       last_done_o,
	output logic       busy_o
);

	logic xfer;
	logic keyed;
	logic keep;
	logic [6:0] gain;
	logic [11:0] r_prod;
	logic [12:0] g_prod;
	logic [11:0] b_prod;
	rgb565_t scaled;

	assign pipe_ack_o = ~pipe_stb_o | pipe_ack_i;
	assign xfer = pipe_stb_i & pipe_ack_o;
	assign busy_o = pipe_stb_o;
	assign last_done_o = pipe_stb_o & pipe_ack_i & pix_o.last;

	// gain of 64 at full brightness, so 63 leaves colours unchanged.
	always_comb begin
		gain = brightness_i + 7'd1;
		r_prod = pix_i.color.r * gain;
		g_prod = pix_i.color.g * gain;
		b_prod = pix_i.color.b * gain;
		scaled.r = r_prod[10:6];
		scaled.g = g_prod[11:6];
		scaled.b = b_prod[10:6];
		keyed = chroma_key_en_i & (pix_i.color == chroma_key_i);
		keep = valid_i & ~keyed;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			pipe_stb_o <= 1'b0;
		else if (xfer)
			pipe_stb_o <= keep | pix_i.last;
		else if (pipe_ack_i)
			pipe_stb_o <= 1'b0;
	end

	always_ff @(posedge sys_clk) begin
		if (xfer) begin
			pix_o.dadr <= pix_i.dadr;
			pix_o.color <= scaled;
			pix_o.last <= pix_i.last;
			valid_o <= keep;
		end
	end

endmodule

//--- source/tmu_clip_adr.sv
// ====================
// off-screen filter and address generator.
// ====================

`timescale 1ns/100ps

module tmu_clip_adr
	import tmu_pix_pkg::*;
(
	input  logic              sys_clk,
	input  logic              sys_rst,
	input  logic              run_i,
	input  logic              pipe_stb_i,
	output logic              pipe_ack_o,
	input  pix_in_t           pix_i,
	input  logic [dadr_w-1:0] dst_fbuf_i,
	input  res_t              dst_hres_i,
	input  res_t              dst_vres_i,
	output logic              pipe_stb_o,
	input  logic              pipe_ack_i,
	output pix_adr_t          pix_o,
	output logic              valid_o,
	output logic              busy_o
);

	logic xfer;
	logic on_screen;
	logic [21:0] row_ofs;
	logic [dadr_w-1:0] dadr;

	assign pipe_ack_o = run_i & (~pipe_stb_o | pipe_ack_i);
	assign xfer = pipe_stb_i & pipe_ack_o;
	assign busy_o = pipe_stb_o;

	// sign bit set means left of or above the frame.
	always_comb begin
		on_screen = ~pix_i.x[11] & ~pix_i.y[11]
			& (pix_i.x[10:0] < dst_hres_i) & (pix_i.y[10:0] < dst_vres_i);
		row_ofs = pix_i.y[10:0] * dst_hres_i;
		dadr = dst_fbuf_i + row_ofs + pix_i.x[10:0];
	end

	// a dropped last pixel still goes out as an empty marker.
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			pipe_stb_o <= 1'b0;
		else if (xfer)
			pipe_stb_o <= on_screen | pix_i.last;
		else if (pipe_ack_i)
			pipe_stb_o <= 1'b0;
	end

	always_ff @(posedge sys_clk) begin
		if (xfer) begin
			pix_o.dadr <= dadr;
			pix_o.color <= pix_i.color;
			pix_o.last <= pix_i.last;
			valid_o <= on_screen;
		end
	end

endmodule

//--- source/tmu_ctlif.sv
// ====================
// CSR registers, run FSM and irq.
// ====================

`timescale 1ns/100ps

module tmu_ctlif
	import tmu_pix_pkg::*;
	import tmu_regs_pkg::*;
(
	input  logic        sys_clk,
	input  logic        sys_rst,
	input  logic [13:0] csr_a_i,
	input  logic        csr_we_i,
	input  logic [31:0] csr_di_i,
	output logic [31:0] csr_do_o,
	input  tmu_busy_t   stage_busy_i,
	input  logic        last_done_i,
	output tmu_cfg_t    cfg_o,
	output logic        run_o,
	output logic        flush_o,
	output logic        irq_o
);

	typedef enum logic [1:0] {st_idle, st_process, st_flush, st_wait_flush} state_t;

	state_t state;
	logic csr_hit;
	logic [9:0] csr_word;
	logic start;
	logic any_busy;
	logic last_seen;

	assign csr_hit = csr_a_i[13:10] == csr_sel;
	assign csr_word = csr_a_i[9:0];
	assign start = csr_we_i & csr_hit & (csr_word == reg_ctrl) & csr_di_i[ctrl_start_bit];
	assign any_busy = |stage_busy_i;
	assign run_o = state != st_idle;
	assign flush_o = state == st_flush;

	// register writes and registered read data.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			cfg_o <= '0;
			csr_do_o <= '0;
		end else begin
			if (csr_we_i && csr_hit) begin
				case (csr_word)
					reg_ctrl:       cfg_o.chroma_key_en <= csr_di_i[ctrl_key_en_bit];
					reg_brightness: cfg_o.brightness <= csr_di_i[5:0];
					reg_chroma_key: cfg_o.chroma_key <= csr_di_i[15:0];
					reg_dst_fbuf:   cfg_o.dst_fbuf <= csr_di_i[dadr_w-1:0];
					reg_dst_hres:   cfg_o.dst_hres <= csr_di_i[10:0];
					reg_dst_vres:   cfg_o.dst_vres <= csr_di_i[10:0];
					default: ;
				endcase
			end
			csr_do_o <= '0;
			if (csr_hit) begin
				case (csr_word)
					reg_ctrl: begin
						csr_do_o[ctrl_busy_bit] <= run_o;
						csr_do_o[ctrl_key_en_bit] <= cfg_o.chroma_key_en;
					end
					reg_brightness: csr_do_o[5:0] <= cfg_o.brightness;
					reg_chroma_key: csr_do_o[15:0] <= cfg_o.chroma_key;
					reg_dst_fbuf:   csr_do_o[dadr_w-1:0] <= cfg_o.dst_fbuf;
					reg_dst_hres:   csr_do_o[10:0] <= cfg_o.dst_hres;
					reg_dst_vres:   csr_do_o[10:0] <= cfg_o.dst_vres;
					default: ;
				endcase
			end
		end
	end

	// process until the last pixel is past decay and the pipe drains.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= st_idle;
			last_seen <= 1'b0;
			irq_o <= 1'b0;
		end else begin
			irq_o <= 1'b0;
			case (state)
				st_idle: begin
					last_seen <= 1'b0;
					if (start)
						state <= st_process;
				end
				st_process: begin
					if (last_done_i)
						last_seen <= 1'b1;
					if (last_seen && !any_busy)
						state <= st_flush;
				end
				st_flush: state <= st_wait_flush;
				st_wait_flush: begin
					if (!any_busy) begin
						state <= st_idle;
						irq_o <= 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

//--- source/tmu_regs_pkg.sv
// ====================
// register map, CSR base select
// and the configuration struct.
// ====================

package tmu_regs_pkg;

	import tmu_pix_pkg::*;

	// compared against csr_a bits 13:10.
	localparam logic [3:0] csr_sel = 4'h0;

	// word indices within the block.
	localparam logic [9:0] reg_ctrl = 10'd0;
	localparam logic [9:0] reg_brightness = 10'd1;
	localparam logic [9:0] reg_chroma_key = 10'd2;
	localparam logic [9:0] reg_dst_fbuf = 10'd3;
	localparam logic [9:0] reg_dst_hres = 10'd4;
	localparam logic [9:0] reg_dst_vres = 10'd5;

	// ctrl register bits.
	localparam int ctrl_start_bit = 0;
	localparam int ctrl_busy_bit = 0;
	localparam int ctrl_key_en_bit = 1;

	typedef struct packed {
		logic [5:0] brightness;
		logic chroma_key_en;
		rgb565_t chroma_key;
		logic [dadr_w-1:0] dst_fbuf;
		res_t dst_hres;
		res_t dst_vres;
	} tmu_cfg_t;

endpackage

//--- source/tmu_pix_pkg.sv
// ====================
// pixel, address and burst formats,
// stage payloads and stage busy flags.
// ====================

package tmu_pix_pkg;

	// memory byte address width.
	localparam int fml_depth = 26;
	// 16-bit word address.
	localparam int dadr_w = fml_depth - 1;
	// 32-byte burst address.
	localparam int burst_adr_w = fml_depth - 5;
	localparam int pixels_per_burst = 16;
	localparam int beats_per_burst = 4;

	typedef logic signed [11:0] coord_t;
	typedef logic [10:0] res_t;

	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;

	// textured pixel as it enters the back end.
	typedef struct packed {
		coord_t x;
		coord_t y;
		rgb565_t color;
		logic last;
	} pix_in_t;

	typedef struct packed {
		logic [dadr_w-1:0] dadr;
		rgb565_t color;
		logic last;
	} pix_adr_t;

	// slot 0 sits in the top 16 bits of data and the top bit of sel.
	typedef struct packed {
		logic [burst_adr_w-1:0] burst_addr;
		logic [pixels_per_burst-1:0] sel;
		logic [pixels_per_burst*16-1:0] data;
	} burst_t;

	typedef struct packed {
		logic clip_adr;
		logic decay;
		logic burst;
		logic pixout;
	} tmu_busy_t;

endpackage
